//--- Makefile
# Verilator build and run of the ledger testbench

VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
SIM       ?= sim
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR SIM VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(SIM)
	@out="$$(./$(BUILD_DIR)/$(SIM))"; echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf $(BUILD_DIR)

//--- key_hasher.sv
`timescale 1ns/1ps

module key_hasher #(
	parameter int HASH_ROUNDS = 4
) (
	input  logic             clock,
	input  logic             resetn,
	input  logic             start,
	input  logic [7:0]       key,
	input  logic [7:0]       public_key,
	input  logic [31:0][7:0] sbox_table,
	output logic             done,
	output logic             match
);

	localparam int CW = $clog2(HASH_ROUNDS + 1);

	logic [7:0]    value, cur, nxt;
	logic [CW-1:0] remaining;
	logic          running, step, last;

	// first round is taken straight from the claimed key
	assign cur  = start ? key : value;
	assign nxt  = sbox_table[cur[4:0]] ^ {cur[6:0], cur[7]};
	assign step = start | running;
	assign last = start ? (HASH_ROUNDS == 1) : (remaining == CW'(1));

	always_ff @(posedge clock)
	begin
		if (step)
			value <= nxt;
	end

	always_ff @(posedge clock)
	begin
		if (!resetn)
		begin
			running   <= 1'b0;
			remaining <= '0;
			done      <= 1'b0;
			match     <= 1'b0;
		end
		else
		begin
			done <= step & last;
			if (step)
			begin
				running   <= ~last;
				remaining <= start ? CW'(HASH_ROUNDS - 1) : remaining - 1'b1;
				if (last)
					match <= (nxt == public_key);  // held until the next hash ends
			end
		end
	end

endmodule

//--- ledger_arbiter.sv
`timescale 1ns/1ps

module ledger_arbiter #(
	parameter int LEDGER_DEPTH = 256
) (
	input  logic                            clock,
	input  logic                            resetn,
	input  logic                            eng_valid,
	input  logic                            eng_write,
	input  logic [7:0]                      eng_index,
	input  ledger_pkg::ledger_word          eng_wdata,
	output logic                            eng_grant,
	input  logic                            host_valid,
	input  ledger_pkg::host_req             host,
	output logic                            host_ack,
	output ledger_pkg::ledger_word          host_rdata,
	output logic                            mem_we,
	output logic [$clog2(LEDGER_DEPTH)-1:0] mem_index,
	output ledger_pkg::ledger_word          mem_wdata,
	input  ledger_pkg::ledger_word          mem_rdata
);

	localparam int IW = $clog2(LEDGER_DEPTH);

	ledger_pkg::host_req pend;
	logic                pend_valid;
	logic                host_grant;

	assign eng_grant  = eng_valid;  // engine never waits
	assign host_grant = pend_valid & ~eng_valid;

	// ------------------------------
	// pending host slot
	// ------------------------------

	always_ff @(posedge clock)
	begin
		if (host_valid)
			pend <= host;
	end

	always_ff @(posedge clock)
	begin
		if (!resetn)
		begin
			pend_valid <= 1'b0;
			host_ack   <= 1'b0;
		end
		else
		begin
			if (host_valid)
				pend_valid <= 1'b1;
			else if (host_grant)
				pend_valid <= 1'b0;
			host_ack <= host_grant;  // read data lands with the ack
		end
	end

	always_comb
	begin
		if (eng_valid)
		begin
			mem_we    = eng_write;
			mem_index = eng_index[IW-1:0];
			mem_wdata = eng_wdata;
		end
		else
		begin
			mem_we    = host_grant & pend.write;
			mem_index = pend.index[IW-1:0];
			mem_wdata = pend.data;
		end
	end

	assign host_rdata = mem_rdata;

endmodule

//--- ledger_memory.sv
`timescale 1ns/1ps

module ledger_memory #(
	parameter int LEDGER_DEPTH = 256
) (
	input  logic                            clock,
	input  logic                            we,
	input  logic [$clog2(LEDGER_DEPTH)-1:0] index,
	input  ledger_pkg::ledger_word          wdata,
	output ledger_pkg::ledger_word          rdata
);

	logic [47:0] mem [LEDGER_DEPTH];

	// every record starts out as zero
	initial
	begin
		for (int i = 0; i < LEDGER_DEPTH; i++)
			mem[i] = '0;
	end

	always_ff @(posedge clock)
	begin
		if (we)
			mem[index] <= wdata.raw;
		rdata.raw <= mem[index];  // old data on a write cycle
	end

endmodule

//--- ledger_pkg.sv
package ledger_pkg;

	// ------------------------------
	// ledger records
	// ------------------------------

	typedef struct packed
	{
		logic [7:0] private_key;  // stored and carried, never checked
		logic [7:0] public_key;
		logic [7:0] balance;
	} player_entry;

	typedef struct packed
	{
		player_entry p1;  // upper 24 bits of the word
		player_entry p2;
	} record_fields;

	// host moves whole words, the datapath works on the fields
	typedef union packed
	{
		logic [47:0]  raw;
		record_fields fields;
	} ledger_word;

	// ------------------------------
	// requests and results
	// ------------------------------

	typedef struct packed
	{
		logic [7:0] index;
		logic       payer;  // 0 = p1 pays p2
		logic [7:0] amount;
		logic [7:0] key;
	} transfer_req;

	typedef enum logic [1:0] {st_ok, st_bad_amount, st_bad_key} transfer_status;

	typedef struct packed
	{
		logic       write;
		logic [7:0] index;
		ledger_word data;
	} host_req;

	typedef enum logic [2:0] {proc_idle, proc_amount, proc_key, proc_commit} process_code;

endpackage

//--- ledger_stim.txt
# s base e0..e7 (table) | w idx word | r idx expected_word
# t idx payer amount key expected_status | c as t, then read idx and expected_word mid-transfer
s 00 05 0D 15 1D 25 2D 35 3D
s 08 45 4D 55 5D 65 6D 75 7D
s 10 85 8D 95 9D A5 AD B5 BD
s 18 C5 CD D5 DD E5 ED F5 FD
w 05 11F56422D032
w 80 33D02044F5F0
w FF A1B2C3D4E5F6
w 00 0123456789AB
r 05 11F56422D032
r 80 33D02044F5F0
r FF A1B2C3D4E5F6
r 00 0123456789AB
t 05 0 14 3C 0
r 05 11F55022D046
t 05 1 05 5A 0
r 05 11F55522D041
t 05 0 00 3C 1
t 05 0 56 3C 1
t 80 0 10 5A 1
r 80 33D02044F5F0
t 05 0 10 3D 2
t 05 1 10 3C 2
r 05 11F55522D041
c 80 1 20 3C 0 00 0123456789AB
r 80 33D04044F5D0

//--- ledger_top.sv
`timescale 1ns/1ps

module ledger_top #(
	parameter int LEDGER_DEPTH = 256,
	parameter int HASH_ROUNDS  = 4
) (
	input  logic                       clock,
	input  logic                       resetn,
	input  logic                       req_valid,
	input  ledger_pkg::transfer_req    req,
	input  logic                       host_valid,
	input  ledger_pkg::host_req        host,
	input  logic [31:0][7:0]           sbox_table,
	output logic                       busy,
	output logic                       done,
	output ledger_pkg::transfer_status status,
	output logic                       host_ack,
	output ledger_pkg::ledger_word     host_rdata
);

	logic                            eng_valid, eng_write, eng_grant;
	logic [7:0]                      eng_index;
	ledger_pkg::ledger_word          eng_wdata;
	logic                            mem_we;
	logic [$clog2(LEDGER_DEPTH)-1:0] mem_index;
	ledger_pkg::ledger_word          mem_wdata, mem_rdata;
	ledger_pkg::process_code         process;
	logic                            load_req, load_record, key_start, commit;
	logic                            amount_ok, key_done, key_ok;

	ledger_memory #(.LEDGER_DEPTH(LEDGER_DEPTH)) ledger_memory_inst (
		.clock(clock), .we(mem_we), .index(mem_index), .wdata(mem_wdata), .rdata(mem_rdata)
	);

	ledger_arbiter #(.LEDGER_DEPTH(LEDGER_DEPTH)) ledger_arbiter_inst (
		.clock(clock), .resetn(resetn),
		.eng_valid(eng_valid), .eng_write(eng_write), .eng_index(eng_index),
		.eng_wdata(eng_wdata), .eng_grant(eng_grant),
		.host_valid(host_valid), .host(host), .host_ack(host_ack), .host_rdata(host_rdata),
		.mem_we(mem_we), .mem_index(mem_index), .mem_wdata(mem_wdata), .mem_rdata(mem_rdata)
	);

	transfer_controller transfer_controller_inst (
		.clock(clock), .resetn(resetn), .req_valid(req_valid), .busy(busy), .done(done),
		.eng_valid(eng_valid), .eng_write(eng_write), .eng_grant(eng_grant),
		.process(process), .load_req(load_req), .load_record(load_record),
		.key_start(key_start), .commit(commit),
		.amount_ok(amount_ok), .key_done(key_done), .key_ok(key_ok), .status(status)
	);

	transfer_datapath #(.HASH_ROUNDS(HASH_ROUNDS)) transfer_datapath_inst (
		.clock(clock), .resetn(resetn), .req(req), .load_req(load_req),
		.mem_rdata(mem_rdata), .load_record(load_record), .process(process),
		.commit(commit), .sbox_table(sbox_table), .amount_ok(amount_ok),
		.key_start(key_start), .key_done(key_done), .key_ok(key_ok),
		.eng_index(eng_index), .eng_wdata(eng_wdata)
	);

endmodule

//--- project.f
ledger_pkg.sv
ledger_memory.sv
ledger_arbiter.sv
key_hasher.sv
transfer_controller.sv
transfer_datapath.sv
ledger_top.sv
tb_clock.sv
tb_checker.sv
tb_top.sv

//--- tb_checker.sv
`timescale 1ns/1ps

module tb_checker (
	input  logic                       clock,
	input  logic                       resetn,
	input  logic                       req_valid,
	input  logic                       busy,
	input  logic                       done,
	input  ledger_pkg::transfer_status status,
	input  logic                       host_ack,
	input  ledger_pkg::ledger_word     host_rdata,
	input  int                         dones_expected,
	input  ledger_pkg::transfer_status exp_status,
	input  int                         acks_expected,
	input  logic                       exp_read,
	input  logic [47:0]                exp_rdata,
	output int                         errors
);

	int   err_count  = 0;
	int   dones_seen = 0;
	int   acks_seen  = 0;
	logic busy_exp   = 1'b0;

	assign errors = err_count;

	// outputs are sampled mid-cycle, away from the driving edge
	always @(negedge clock)
	begin
		if (resetn)
		begin
			if (busy !== busy_exp)
			begin
				$display("ERROR time=%0t signal=busy expected=%b actual=%b",
					$time, busy_exp, busy);
				err_count++;
			end
			if (done)
				busy_exp = 1'b0;  // idle again after the report cycle
			else if (req_valid && !busy_exp)
				busy_exp = 1'b1;  // taken on the next edge
		end
		if (resetn && done)
		begin
			dones_seen++;
			if (dones_seen > dones_expected)
			begin
				$display("%0t: done pulsed with no transfer outstanding", $time);
				err_count++;
			end
			else if (status !== exp_status)
			begin
				$display("ERROR time=%0t signal=status expected=%s actual=%s",
					$time, exp_status.name(), status.name());
				err_count++;
			end
		end
		if (resetn && host_ack)
		begin
			acks_seen++;
			if (acks_seen > acks_expected)
			begin
				$display("%0t: host_ack with no host operation outstanding", $time);
				err_count++;
			end
			else if (exp_read && host_rdata.raw !== exp_rdata)  // writes only count the ack
			begin
				$display("ERROR time=%0t signal=host_rdata expected=%h actual=%h",
					$time, exp_rdata, host_rdata.raw);
				err_count++;
			end
		end
	end

endmodule

//--- tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
	parameter int PERIOD_NS    = 4,
	parameter int RESET_CYCLES = 8
) (
	output logic clock,
	output logic resetn
);

	initial
	begin
		clock = 1'b0;
		forever #(PERIOD_NS / 2.0) clock = ~clock;
	end

	initial
	begin
		resetn = 1'b0;
		repeat (RESET_CYCLES) @(posedge clock);
		resetn <= 1'b1;  // released on an edge, sync reset
	end

endmodule

//--- tb_top.sv
`timescale 1ns/1ps

module tb_top;

	localparam int LEDGER_DEPTH = 256;
	localparam int HASH_ROUNDS  = 4;
	localparam int LIMIT        = 200;  // cycles per wait

	logic                       clock, resetn;
	logic                       req_valid, host_valid, busy, done, host_ack, exp_read;
	ledger_pkg::transfer_req    req;
	ledger_pkg::host_req        host;
	logic [31:0][7:0]           sbox_table;
	ledger_pkg::transfer_status status, exp_status;
	ledger_pkg::ledger_word     host_rdata;
	logic [47:0]                exp_rdata;
	int                         dones_expected, acks_expected, check_errors;
	int                         run_errors = 0;
	int                         seed = 32'h00af6912;

	tb_clock #(.PERIOD_NS(4), .RESET_CYCLES(8)) clock_gen (.clock(clock), .resetn(resetn));

	ledger_top #(.LEDGER_DEPTH(LEDGER_DEPTH), .HASH_ROUNDS(HASH_ROUNDS)) ledger_top_inst (
		.clock(clock), .resetn(resetn), .req_valid(req_valid), .req(req),
		.host_valid(host_valid), .host(host), .sbox_table(sbox_table), .busy(busy),
		.done(done), .status(status), .host_ack(host_ack), .host_rdata(host_rdata)
	);

	tb_checker checker_inst (
		.clock(clock), .resetn(resetn), .req_valid(req_valid), .busy(busy),
		.done(done), .status(status),
		.host_ack(host_ack), .host_rdata(host_rdata), .dones_expected(dones_expected),
		.exp_status(exp_status), .acks_expected(acks_expected), .exp_read(exp_read),
		.exp_rdata(exp_rdata), .errors(check_errors)
	);

	// ------------------------------
	// drive and wait helpers
	// ------------------------------

	task automatic idle_gap();
		int n;
		n = $unsigned($random(seed)) % 4;
		for (int i = 0; i < n; i++)
			@(posedge clock);
	endtask

	task automatic wait_events(input logic want_done, input logic want_ack);
		int   n;
		logic got_done, got_ack;
		n        = 0;
		got_done = !want_done;
		got_ack  = !want_ack;
		while (!(got_done && got_ack) && n < LIMIT)
		begin
			@(negedge clock);
			got_done |= done;
			got_ack  |= host_ack;
			n++;
		end
		if (!got_done)
		begin
			$display("%0t: transfer gave no done within %0d cycles", $time, LIMIT);
			run_errors++;
		end
		if (!got_ack)
		begin
			$display("%0t: host operation gave no host_ack within %0d cycles", $time, LIMIT);
			run_errors++;
		end
	endtask

	task automatic start_host(input logic write, input int idx, input logic [47:0] word);
		host_valid    <= 1'b1;
		host          <= {write, idx[7:0], word};
		exp_read      <= !write;
		exp_rdata     <= word;
		acks_expected <= acks_expected + 1;
	endtask

	task automatic start_transfer(input int idx, input int payer, input int amount,
		input int key, input int st);
		req_valid      <= 1'b1;
		req            <= {idx[7:0], payer[0], amount[7:0], key[7:0]};
		exp_status     <= ledger_pkg::transfer_status'(st[1:0]);
		dones_expected <= dones_expected + 1;
	endtask

	initial
	begin
		int          fd, n, base, idx, payer, amount, key, st, ridx;
		logic [47:0] word, rword;
		logic [7:0]  e [8];
		string       line, cmd;
		req_valid      = 1'b0;
		req            = '0;
		host_valid     = 1'b0;
		host           = '0;
		sbox_table     = '0;
		exp_read       = 1'b0;
		exp_rdata      = '0;
		exp_status     = ledger_pkg::st_ok;
		dones_expected = 0;
		acks_expected  = 0;
		n = 0;
		while (resetn !== 1'b1 && n < LIMIT)
		begin
			@(posedge clock);
			n++;
		end
		if (resetn !== 1'b1)
		begin
			$display("reset was never released");
			run_errors++;
		end
		fd = $fopen("ledger_stim.txt", "r");
		if (fd == 0)
		begin
			$display("could not open ledger_stim.txt");
			run_errors++;
		end
		while (fd != 0 && !$feof(fd))
		begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() == 0 || line[0] == "#")
				continue;
			cmd = "";
			void'($sscanf(line, "%s", cmd));
			case (cmd)
				"s":
				begin
					void'($sscanf(line, "%s %h %h %h %h %h %h %h %h %h", cmd, base,
						e[0], e[1], e[2], e[3], e[4], e[5], e[6], e[7]));
					@(posedge clock);
					for (int i = 0; i < 8; i++)
						sbox_table[base + i] <= e[i];
				end
				"w", "r":
				begin
					void'($sscanf(line, "%s %h %h", cmd, idx, word));
					idle_gap();
					@(posedge clock);
					start_host(cmd == "w", idx, word);
					@(posedge clock);
					host_valid <= 1'b0;
					wait_events(1'b0, 1'b1);
				end
				"t", "c":
				begin
					void'($sscanf(line, "%s %h %h %h %h %h %h %h", cmd, idx, payer, amount,
						key, st, ridx, rword));
					idle_gap();
					@(posedge clock);
					start_transfer(idx, payer, amount, key, st);
					@(posedge clock);
					req_valid <= 1'b0;
					if (cmd == "c")
					begin
						start_host(1'b0, ridx, rword);  // read lands mid-transfer
						@(posedge clock);
						host_valid <= 1'b0;
						req_valid  <= 1'b1;  // strobe while busy, must be dropped
						@(posedge clock);
						req_valid <= 1'b0;
					end
					wait_events(1'b1, cmd == "c");
					for (int i = 0; i < HASH_ROUNDS + 10; i++)
						@(posedge clock);
				end
				default:
				begin
				end
			endcase
		end
		if (fd != 0)
			$fclose(fd);
		$display("closing: %0d check errors, %0d run errors", check_errors, run_errors);
		if (check_errors == 0 && run_errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

//--- transfer_controller.sv
`timescale 1ns/1ps

module transfer_controller (
	input  logic                       clock,
	input  logic                       resetn,
	input  logic                       req_valid,
	output logic                       busy,
	output logic                       done,
	output logic                       eng_valid,
	output logic                       eng_write,
	input  logic                       eng_grant,
	output ledger_pkg::process_code    process,
	output logic                       load_req,
	output logic                       load_record,
	output logic                       key_start,
	output logic                       commit,
	input  logic                       amount_ok,
	input  logic                       key_done,
	input  logic                       key_ok,
	output ledger_pkg::transfer_status status
);

	typedef enum logic [2:0] {
		s_idle, s_read, s_wait_data, s_check_amount, s_hash, s_write, s_report
	} state_t;

	state_t                    state, state_next;
	ledger_pkg::transfer_status status_next;
	logic                      hash_active;

	always_ff @(posedge clock)
	begin
		if (!resetn)
		begin
			state       <= s_idle;
			status      <= ledger_pkg::st_ok;
			hash_active <= 1'b0;
		end
		else
		begin
			state       <= state_next;
			status      <= status_next;
			hash_active <= (state_next == s_hash) & (hash_active | key_start);
		end
	end

	always_comb
	begin
		state_next  = state;
		status_next = status;
		case (state)
			s_idle:         if (req_valid) state_next = s_read;
			s_read:         if (eng_grant) state_next = s_wait_data;
			s_wait_data:    state_next = s_check_amount;
			s_check_amount: state_next = s_hash;
			s_hash:
			begin
				if (!hash_active && !amount_ok)
				begin
					status_next = ledger_pkg::st_bad_amount;  // no hash, no write
					state_next  = s_report;
				end
				else if (key_done)
				begin
					status_next = key_ok ? ledger_pkg::st_ok : ledger_pkg::st_bad_key;
					state_next  = key_ok ? s_write : s_report;
				end
			end
			s_write:        if (eng_grant) state_next = s_report;
			default:        state_next = s_idle;
		endcase
	end

	always_comb
	begin
		case (state)
			s_check_amount: process = ledger_pkg::proc_amount;
			s_hash:         process = ledger_pkg::proc_key;
			s_write:        process = ledger_pkg::proc_commit;
			default:        process = ledger_pkg::proc_idle;
		endcase
	end

	assign busy        = (state != s_idle);
	assign done        = (state == s_report);
	assign eng_valid   = (state == s_read) || (state == s_write);
	assign eng_write   = (state == s_write);
	assign load_req    = (state == s_idle) && req_valid;  // strobes while busy fall here
	assign load_record = (state == s_wait_data);
	assign key_start   = (state == s_hash) && amount_ok && !hash_active;
	assign commit      = (state == s_write) && eng_grant;

endmodule

//--- transfer_datapath.sv
`timescale 1ns/1ps

module transfer_datapath #(
	parameter int HASH_ROUNDS = 4
) (
	input  logic                    clock,
	input  logic                    resetn,
	input  ledger_pkg::transfer_req req,
	input  logic                    load_req,
	input  ledger_pkg::ledger_word  mem_rdata,
	input  logic                    load_record,
	input  ledger_pkg::process_code process,
	input  logic                    commit,
	input  logic [31:0][7:0]        sbox_table,
	output logic                    amount_ok,
	input  logic                    key_start,
	output logic                    key_done,
	output logic                    key_ok,
	output logic [7:0]              eng_index,
	output ledger_pkg::ledger_word  eng_wdata
);

	ledger_pkg::transfer_req req_q;
	ledger_pkg::ledger_word  record_q;
	ledger_pkg::player_entry payer, payee;
	logic [8:0]              payee_sum;
	logic                    amount_check;

	always_ff @(posedge clock)
	begin
		if (load_req)
			req_q <= req;
	end

	always_ff @(posedge clock)
	begin
		if (load_record)
			record_q <= mem_rdata;
		else if (commit)
			record_q <= eng_wdata;  // keep the local copy in step with memory
	end

	// ------------------------------
	// amount check
	// ------------------------------

	assign payer     = req_q.payer ? record_q.fields.p2 : record_q.fields.p1;
	assign payee     = req_q.payer ? record_q.fields.p1 : record_q.fields.p2;
	assign payee_sum = {1'b0, payee.balance} + {1'b0, req_q.amount};

	assign amount_check = (req_q.amount != 8'd0) && (req_q.amount <= payer.balance)
		&& !payee_sum[8];

	always_ff @(posedge clock)
	begin
		if (!resetn)
			amount_ok <= 1'b0;
		else if (process == ledger_pkg::proc_amount)
			amount_ok <= amount_check;
	end

	// updated record, keys pass through untouched
	always_comb
	begin
		eng_wdata = record_q;
		if (req_q.payer)
		begin
			eng_wdata.fields.p2.balance = payer.balance - req_q.amount;
			eng_wdata.fields.p1.balance = payee_sum[7:0];
		end
		else
		begin
			eng_wdata.fields.p1.balance = payer.balance - req_q.amount;
			eng_wdata.fields.p2.balance = payee_sum[7:0];
		end
	end

	assign eng_index = req_q.index;

	key_hasher #(
		.HASH_ROUNDS(HASH_ROUNDS)
	) key_hasher_inst (
		.clock     (clock),
		.resetn    (resetn),
		.start     (key_start),
		.key       (req_q.key),
		.public_key(payer.public_key),
		.sbox_table(sbox_table),
		.done      (key_done),
		.match     (key_ok)
	);

endmodule
